// File: dv/icache_stimulus.txt
# columns: test name, opcode (0 fetch, 1 invalidate), word address (hex),
# expected data (hex), expected hit (0 or 1)
inv_init      1 000 00000000 0
miss_first    0 014 a5a50014 0
hit_word1     0 015 a5a50015 1
hit_word2     0 016 a5a50016 1
hit_word3     0 017 a5a50017 1
hit_word0     0 014 a5a50014 1
conflict      0 054 a5a50054 0
conflict_hit  0 057 a5a50057 1
refetch_orig  0 014 a5a50014 0
refetch_hit   0 016 a5a50016 1
other_line    0 3a9 a5a503a9 0
other_hit     0 3ab a5a503ab 1
inv_mid       1 000 00000000 0
after_inv_a   0 016 a5a50016 0
after_inv_b   0 3ab a5a503ab 0
after_inv_hit 0 3a8 a5a503a8 1
high_tag      0 fff a5a50fff 0

// File: all.f
hdl/icache_geom_pkg.sv
hdl/icache_bus_pkg.sv
hdl/icache_tag_ram.sv
hdl/icache_data_ram.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
dv/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - hdl/icache_geom_pkg.sv
      - hdl/icache_bus_pkg.sv
      - hdl/icache_tag_ram.sv
      - hdl/icache_data_ram.sv
      - hdl/icache_ctrl.sv
      - hdl/icache_top.sv
  - target: simulation
    files:
      - dv/icache_tb.sv

// File: dv/icache_tb.sv
// Testbench for the instruction cache; replays the stimulus file against a random-delay memory.
`timescale 1ns/1ps

module icache_tb import icache_geom_pkg::*, icache_bus_pkg::*; ();

	localparam int    RESET_CYCLES = 8;
	localparam int    STEP_CYCLES  = 60; // covers 16 tag writes or four slow refill beats.
	localparam int    HIT_LATENCY  = 3;
	localparam data_t MEM_PATTERN  = 32'hA5A50000;

	logic       clk;
	logic       arst_n;
	logic       fetch_req;
	fetch_req_t fetch_cmd;
	logic       fetch_ack;
	fetch_rsp_t fetch_rsp;
	logic       mem_req;
	mem_req_t   mem_cmd;
	logic       mem_ack;
	data_t      mem_rdata;

	string       step_name[$];
	int          step_op[$];
	addr_t       step_addr[$];
	data_t       step_data[$];
	logic        step_hit[$];
	int unsigned cycle_cnt;
	int unsigned cycle_limit;
	int unsigned ack_gap;
	int          pass_cnt;
	int          fail_cnt;
	logic        reset_ok;

	icache_top #(
		.INDEX_W  (DEF_INDEX_W),
		.OFFSET_W (DEF_OFFSET_W)
	) dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.fetch_req (fetch_req),
		.fetch_cmd (fetch_cmd),
		.fetch_ack (fetch_ack),
		.fetch_rsp (fetch_rsp),
		.mem_req   (mem_req),
		.mem_cmd   (mem_cmd),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	always #4 clk = ~clk;

	// the backing memory word is the address zero-extended and XORed with a fixed pattern.
	function automatic data_t memory_word(input addr_t a);
		return data_t'(a) ^ MEM_PATTERN;
	endfunction

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
			$display("timeout: a fetch or memory handshake never completed within %0d cycles",
				cycle_limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// memory responder that answers each mem_req with one four-phase beat.
	initial begin
		void'($urandom(43));
		forever begin
			@(posedge clk);
			#1;
			if (arst_n && mem_req && !mem_ack) begin
				ack_gap = $urandom % 6;
				repeat (ack_gap) begin
					@(posedge clk);
					#1;
				end
				mem_rdata = memory_word(mem_cmd.addr);
				mem_ack   = 1'b1;
				do begin
					@(posedge clk);
					#1;
				end while (mem_req);
				mem_ack = 1'b0; // the controller has captured the word.
			end
		end
	end

	task automatic report_test(input string name, input logic ok);
		if (ok) begin
			pass_cnt++;
			$display("%-14s pass", name);
		end else begin
			fail_cnt++;
			$display("%-14s fail", name);
		end
	endtask

	task automatic load_stimulus();
		int    fd;
		int    fields;
		string line;
		string name;
		int    op;
		int    hit;
		addr_t addr;
		data_t data;
		fd = $fopen("dv/icache_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file dv/icache_stimulus.txt");
			fail_cnt++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// skip comments and blank lines.
				if (line.len() > 1 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%s %d %h %h %d", name, op, addr, data, hit);
					if (fields == 5) begin
						step_name.push_back(name);
						step_op.push_back(op);
						step_addr.push_back(addr);
						step_data.push_back(data);
						step_hit.push_back(hit != 0);
					end
				end
			end
			$fclose(fd);
			if (step_name.size() == 0) begin
				$display("the stimulus file holds no test steps");
				fail_cnt++;
			end
		end
		cycle_limit = step_name.size() * STEP_CYCLES + RESET_CYCLES;
	endtask

	task automatic run_step(input int idx);
		int         edges;
		fetch_rsp_t got;
		logic       ok;
		ok = 1'b1;
		@(posedge clk);
		#1;
		fetch_cmd.op   = (step_op[idx] != 0) ? op_invalidate : op_fetch;
		fetch_cmd.addr = step_addr[idx];
		fetch_req      = 1'b1;
		edges          = 0;
		do begin
			@(posedge clk);
			#1;
			edges++;
		end while (!fetch_ack);
		got       = fetch_rsp;
		fetch_req = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (fetch_ack);
		if (got.data !== step_data[idx]) begin
			$display("error: %s data expected %h actual %h", step_name[idx], step_data[idx],
				got.data);
			ok = 1'b0;
		end
		if (got.hit !== step_hit[idx]) begin
			$display("error: %s hit expected %0d actual %0d", step_name[idx], step_hit[idx],
				got.hit);
			ok = 1'b0;
		end
		// the first edge counted is the one that sampled req.
		if (step_hit[idx] && edges - 1 != HIT_LATENCY) begin
			$display("error: %s ack latency expected %0d actual %0d", step_name[idx], HIT_LATENCY,
				edges - 1);
			ok = 1'b0;
		end
		report_test(step_name[idx], ok);
	endtask

	initial begin
		clk         = 1'b0;
		arst_n      = 1'b0;
		fetch_req   = 1'b0;
		fetch_cmd   = '0;
		mem_ack     = 1'b0;
		mem_rdata   = '0;
		cycle_cnt   = 0;
		cycle_limit = 0;
		pass_cnt    = 0;
		fail_cnt    = 0;
		load_stimulus();
		reset_ok = 1'b1;
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			#1;
			if (fetch_ack !== 1'b0 || mem_req !== 1'b0) begin
				$display("fetch_ack or mem_req was not low during reset");
				reset_ok = 1'b0;
			end
		end
		arst_n = 1'b1;
		report_test("reset", reset_ok);
		for (int i = 0; i < step_name.size(); i++) begin
			run_step(i);
		end
		$display("%0d tests run, %0d passed, %0d failed", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: hdl/icache_top.sv
// Top level of the instruction cache; connects the controller to the tag and data RAMs.
`timescale 1ns/1ps

module icache_top import icache_geom_pkg::*, icache_bus_pkg::*; #(
	parameter int INDEX_W  = DEF_INDEX_W,
	parameter int OFFSET_W = DEF_OFFSET_W
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       fetch_req,
	input  fetch_req_t fetch_cmd,
	output logic       fetch_ack,
	output fetch_rsp_t fetch_rsp,
	output logic       mem_req,
	output mem_req_t   mem_cmd,
	input  logic       mem_ack,
	input  data_t      mem_rdata
);

	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W; // what is left above index and offset.

	logic                tag_cs;
	logic                tag_we;
	logic [INDEX_W-1:0]  tag_addr;
	logic [TAG_W:0]      tag_wdata;
	logic [TAG_W:0]      tag_rdata;
	logic                data_cs;
	logic                data_we;
	logic [INDEX_W-1:0]  data_index;
	logic [OFFSET_W-1:0] data_offset;
	data_t               data_wdata;
	data_t               data_rdata;

	icache_ctrl #(
		.INDEX_W  (INDEX_W),
		.OFFSET_W (OFFSET_W),
		.TAG_W    (TAG_W)
	) u_ctrl (
		.clk         (clk),
		.arst_n      (arst_n),
		.fetch_req   (fetch_req),
		.fetch_cmd   (fetch_cmd),
		.fetch_ack   (fetch_ack),
		.fetch_rsp   (fetch_rsp),
		.mem_req     (mem_req),
		.mem_cmd     (mem_cmd),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata),
		.tag_cs      (tag_cs),
		.tag_we      (tag_we),
		.tag_addr    (tag_addr),
		.tag_wdata   (tag_wdata),
		.tag_rdata   (tag_rdata),
		.data_cs     (data_cs),
		.data_we     (data_we),
		.data_index  (data_index),
		.data_offset (data_offset),
		.data_wdata  (data_wdata),
		.data_rdata  (data_rdata)
	);

	icache_tag_ram #(
		.AW (INDEX_W),
		.DW (TAG_W + 1)
	) u_tag_ram (
		.clk   (clk),
		.cs    (tag_cs),
		.we    (tag_we),
		.addr  (tag_addr),
		.wdata (tag_wdata),
		.rdata (tag_rdata)
	);

	icache_data_ram #(
		.INDEX_W  (INDEX_W),
		.OFFSET_W (OFFSET_W),
		.DW       (DATA_W)
	) u_data_ram (
		.clk    (clk),
		.cs     (data_cs),
		.we     (data_we),
		.index  (data_index),
		.offset (data_offset),
		.wdata  (data_wdata),
		.rdata  (data_rdata)
	);

endmodule

// File: hdl/icache_ctrl.sv
// Cache controller FSM; serves fetches from the RAMs, refills lines on a miss, clears tags.
`timescale 1ns/1ps

module icache_ctrl import icache_geom_pkg::*, icache_bus_pkg::*; #(
	parameter int INDEX_W  = DEF_INDEX_W,
	parameter int OFFSET_W = DEF_OFFSET_W,
	parameter int TAG_W    = ADDR_W - DEF_INDEX_W - DEF_OFFSET_W
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                fetch_req,
	input  fetch_req_t          fetch_cmd,
	output logic                fetch_ack,
	output fetch_rsp_t          fetch_rsp,
	output logic                mem_req,
	output mem_req_t            mem_cmd,
	input  logic                mem_ack,
	input  data_t               mem_rdata,
	output logic                tag_cs,
	output logic                tag_we,
	output logic [INDEX_W-1:0]  tag_addr,
	output logic [TAG_W:0]      tag_wdata,
	input  logic [TAG_W:0]      tag_rdata,
	output logic                data_cs,
	output logic                data_we,
	output logic [INDEX_W-1:0]  data_index,
	output logic [OFFSET_W-1:0] data_offset,
	output data_t               data_wdata,
	input  data_t               data_rdata
);

	ctrl_state_e         state;
	logic [TAG_W-1:0]    req_tag;
	logic [INDEX_W-1:0]  req_index;
	logic [OFFSET_W-1:0] req_offset;
	logic [OFFSET_W-1:0] refill_cnt;
	logic [INDEX_W-1:0]  inv_cnt;
	data_t               rsp_data;
	logic                rsp_hit;
	logic                hit;
	logic                refill_last;
	logic                start;

	assign start       = (state == st_idle) && fetch_req;
	assign hit         = tag_rdata[TAG_W] && (tag_rdata[TAG_W-1:0] == req_tag);
	assign refill_last = (refill_cnt == '1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= st_idle;
			fetch_ack  <= 1'b0;
			mem_req    <= 1'b0;
			refill_cnt <= '0;
			inv_cnt    <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (fetch_req) begin
						if (fetch_cmd.op == op_invalidate) begin
							inv_cnt <= '0;
							state   <= st_invalidate;
						end else begin
							state <= st_lookup;
						end
					end
				end
				st_lookup: state <= st_compare; // both RAMs are being read.
				st_compare: begin
					if (hit) begin
						state <= st_respond;
					end else begin
						refill_cnt <= '0;
						state      <= st_refill_req;
					end
				end
				st_refill_req: begin
					// the previous beat must be fully closed before a new one opens.
					if (!mem_ack) begin
						mem_req <= 1'b1;
						state   <= st_refill_wait;
					end
				end
				st_refill_wait: begin
					if (mem_ack) begin
						mem_req    <= 1'b0;
						refill_cnt <= refill_cnt + 1'b1;
						state      <= refill_last ? st_respond : st_refill_req;
					end
				end
				st_invalidate: begin
					inv_cnt <= inv_cnt + 1'b1;
					if (inv_cnt == '1) begin
						state <= st_respond;
					end
				end
				st_respond: begin
					if (!fetch_ack) begin
						fetch_ack <= 1'b1;
					end else if (!fetch_req) begin
						fetch_ack <= 1'b0; // requester has let go.
						state     <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// request fields and the response word.
	always_ff @(posedge clk) begin
		if (start) begin
			{req_tag, req_index, req_offset} <= fetch_cmd.addr;
			if (fetch_cmd.op == op_invalidate) begin
				rsp_data <= '0;
				rsp_hit  <= 1'b0;
			end
		end
		if (state == st_compare) begin
			rsp_data <= data_rdata; // replaced during refill on a miss.
			rsp_hit  <= hit;
		end
		if (state == st_refill_wait && mem_ack && refill_cnt == req_offset) begin
			rsp_data <= mem_rdata;
		end
	end

	assign fetch_rsp = '{data: rsp_data, hit: rsp_hit};
	assign mem_cmd   = '{addr: {req_tag, req_index, refill_cnt}};

	assign data_wdata = mem_rdata;

	always_comb begin
		tag_cs      = 1'b0;
		tag_we      = 1'b0;
		tag_addr    = req_index;
		tag_wdata   = {1'b1, req_tag};
		data_cs     = 1'b0;
		data_we     = 1'b0;
		data_index  = req_index;
		data_offset = req_offset;
		case (state)
			st_lookup: begin
				tag_cs  = 1'b1;
				data_cs = 1'b1;
			end
			st_refill_wait: begin
				if (mem_ack) begin
					data_cs     = 1'b1;
					data_we     = 1'b1;
					data_offset = refill_cnt;
					// the tag goes valid together with the last word of the line.
					tag_cs = refill_last;
					tag_we = refill_last;
				end
			end
			st_invalidate: begin
				tag_cs    = 1'b1;
				tag_we    = 1'b1;
				tag_addr  = inv_cnt;
				tag_wdata = '0;
			end
			default: begin
			end
		endcase
	end

endmodule

// File: hdl/icache_data_ram.sv
// Single-port synchronous data RAM of the cache, addressed by line index and word offset.
`timescale 1ns/1ps

module icache_data_ram import icache_geom_pkg::*; #(
	parameter int INDEX_W  = DEF_INDEX_W,
	parameter int OFFSET_W = DEF_OFFSET_W,
	parameter int DW       = DATA_W
) (
	input  logic                clk,
	input  logic                cs,
	input  logic                we,
	input  logic [INDEX_W-1:0]  index,
	input  logic [OFFSET_W-1:0] offset,
	input  data_t               wdata,
	output data_t               rdata
);

	localparam int ROW_W = INDEX_W + OFFSET_W;

	logic [DW-1:0]    mem [2**ROW_W];
	logic [ROW_W-1:0] row;

	// words of one line sit in consecutive rows.
	assign row = {index, offset};

	always_ff @(posedge clk) begin
		if (cs) begin
			if (we) begin
				mem[row] <= wdata;
			end else begin
				rdata <= mem[row]; // registered read.
			end
		end
	end

endmodule

// File: hdl/icache_tag_ram.sv
// Single-port synchronous tag RAM, one valid bit above the tag per cache line.
`timescale 1ns/1ps

module icache_tag_ram #(
	parameter int AW = 4,
	parameter int DW = 7
) (
	input  logic          clk,
	input  logic          cs,
	input  logic          we,
	input  logic [AW-1:0] addr,
	input  logic [DW-1:0] wdata,
	output logic [DW-1:0] rdata
);

	logic [DW-1:0] mem [2**AW];

	// nothing moves unless the chip is selected.
	// a read updates rdata one clock later, a write leaves rdata alone.
	always_ff @(posedge clk) begin
		if (cs) begin
			if (we) begin
				mem[addr] <= wdata;
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

// File: hdl/icache_bus_pkg.sv
// Opcode and FSM state encodings plus the fetch and memory handshake structs of the cache.
package icache_bus_pkg;

	import icache_geom_pkg::*;

	typedef enum logic {
		op_fetch      = 1'b0,
		op_invalidate = 1'b1
	} cache_op_e;

	typedef enum logic [2:0] {
		st_idle        = 3'd0,
		st_lookup      = 3'd1,
		st_compare     = 3'd2,
		st_refill_req  = 3'd3,
		st_refill_wait = 3'd4,
		st_respond     = 3'd5,
		st_invalidate  = 3'd6
	} ctrl_state_e;

	// request from the fetch side, held stable while req is high.
	typedef struct packed {
		cache_op_e op;
		addr_t     addr;
	} fetch_req_t;

	// answer to the fetch side, valid while ack is high.
	typedef struct packed {
		data_t data;
		logic  hit;
	} fetch_rsp_t;

	typedef struct packed {
		addr_t addr; // word address of one refill beat.
	} mem_req_t;

endpackage

// File: hdl/icache_geom_pkg.sv
// Cache geometry constants and address-field types, imported by the RTL and the testbench.
package icache_geom_pkg;

	// word-address width of the fetch and refill ports.
	localparam int ADDR_W = 12;

	// one instruction word.
	localparam int DATA_W = 32;

	// default line count is 2**DEF_INDEX_W.
	localparam int DEF_INDEX_W = 4;

	// default words per line is 2**DEF_OFFSET_W.
	localparam int DEF_OFFSET_W = 2;

	// a word address, split by the controller into tag, index and offset.
	typedef logic [ADDR_W-1:0] addr_t;

	typedef logic [DATA_W-1:0] data_t;

endpackage
